// File: include/xpu_config.svh
// xpu sizing constants and fixed version word

`ifndef XPU_CONFIG_SVH
`define XPU_CONFIG_SVH

// register port
`define XPU_REG_DATA_W 32
`define XPU_REG_ADDR_W 4

// tsf timer width, per 802.11
`define XPU_TSF_W 64

// system clock cycles in one microsecond (100 MHz)
`define XPU_CLK_PER_US 100

// header report side channel
`define XPU_HDR_QUEUE_DEPTH 4 // keep a power of two
`define XPU_HDR_CREDITS 4     // consumer slots granted at reset

// build identification, read only
`define XPU_VERSION 32'h0002_0107

`endif

// File: source/xpu_pkg.sv
// shared xpu types for register requests, rx bytes and header records
`default_nettype none

`include "xpu_config.svh"

package xpu_pkg;

    // first received byte sits in bits 7:0
    typedef logic [47:0] mac_addr_t;

    // byte 0 of the frame is the low byte
    typedef struct packed {
        logic [15:0] duration;
        logic        order;
        logic        protected_frame;
        logic        more_data;
        logic        power_manage;
        logic        retry;
        logic        more_frag;
        logic        from_ds;
        logic        to_ds;
        logic [3:0]  subtype;
        logic [1:0]  ftype; // frame type
        logic [1:0]  version;
    } frame_ctrl_t;

    typedef struct packed {
        logic [7:0]  data;
        logic [15:0] idx; // byte position in the mpdu
        logic        valid;
    } rx_byte_t;

    typedef struct packed {
        logic                       wr;
        logic                       rd;
        logic [`XPU_REG_ADDR_W-1:0] addr;
        logic [`XPU_REG_DATA_W-1:0] wdata;
    } reg_req_t;

    typedef struct packed {
        frame_ctrl_t fc;
        mac_addr_t   addr1;
        mac_addr_t   addr2;
        logic        for_me;
    } hdr_rec_t;

    typedef enum logic [`XPU_REG_ADDR_W-1:0] {
        REG_SELF_MAC_LO = 4'd0,
        REG_SELF_MAC_HI = 4'd1,  // 15:0 upper mac bytes, 31 promiscuous
        REG_TSF_LOAD_LO = 4'd2,
        REG_TSF_LOAD_HI = 4'd3,  // write here fires the load
        REG_TSF_LO      = 4'd8,
        REG_TSF_HI      = 4'd9,
        REG_DROP_CNT    = 4'd10,
        REG_VERSION     = 4'd15
    } reg_addr_e;

    typedef enum logic [2:0] {
        P_IDLE,
        P_FC,    // frame control and duration
        P_ADDR1,
        P_ADDR2,
        P_DONE
    } parse_state_e;

endpackage

`default_nettype wire

// File: source/tsf_timer.sv
// 64-bit microsecond tsf timer with software load and 1 MHz strobe
`default_nettype none

`include "xpu_config.svh"

module tsf_timer (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     load_i,
    input  wire [`XPU_TSF_W-1:0]    load_val_i,
    output logic [`XPU_TSF_W-1:0]   tsf_o,
    output logic                    pulse_1m_o
);

    localparam int PRE_W = $clog2(`XPU_CLK_PER_US);
    localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(`XPU_CLK_PER_US - 1);

    logic [PRE_W-1:0] pre_cnt;

    // pulse and tsf step land on the same edge
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            pre_cnt    <= '0;
            pulse_1m_o <= 1'b0;
            tsf_o      <= '0;
        end else if (load_i) begin
            pre_cnt    <= '0; // restart the microsecond phase
            pulse_1m_o <= 1'b0;
            tsf_o      <= load_val_i;
        end else if (pre_cnt == PRE_LAST) begin
            pre_cnt    <= '0;
            pulse_1m_o <= 1'b1;
            tsf_o      <= tsf_o + 1'b1;
        end else begin
            pre_cnt    <= pre_cnt + 1'b1;
            pulse_1m_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/xpu_regs.sv
// xpu control register bank with registered read mux and tsf load strobe
`default_nettype none

`include "xpu_config.svh"

module xpu_regs
    import xpu_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire reg_req_t               reg_req_i,
    input  wire [`XPU_TSF_W-1:0]        tsf_i,
    input  wire [`XPU_REG_DATA_W-1:0]   drop_cnt_i,
    output logic [`XPU_REG_DATA_W-1:0]  rdata_o,
    output logic                        rvalid_o,
    output mac_addr_t                   self_mac_o,
    output logic                        promisc_o,
    output logic [`XPU_TSF_W-1:0]       tsf_load_val_o,
    output logic                        tsf_load_o
);

    reg_addr_e                  addr;
    logic [31:0]                mac_lo_q;
    logic [15:0]                mac_hi_q;
    logic                       promisc_q;
    logic [31:0]                load_lo_q;
    logic [31:0]                load_hi_q;
    logic [`XPU_REG_DATA_W-1:0] rd_mux;

    assign addr = reg_addr_e'(reg_req_i.addr);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mac_lo_q   <= '0;
            mac_hi_q   <= '0;
            promisc_q  <= 1'b0;
            load_lo_q  <= '0;
            load_hi_q  <= '0;
            tsf_load_o <= 1'b0;
            rvalid_o   <= 1'b0;
        end else begin
            tsf_load_o <= 1'b0;
            rvalid_o   <= reg_req_i.rd;
            if (reg_req_i.wr) begin
                case (addr)
                    REG_SELF_MAC_LO: mac_lo_q <= reg_req_i.wdata;
                    REG_SELF_MAC_HI: begin
                        mac_hi_q  <= reg_req_i.wdata[15:0];
                        promisc_q <= reg_req_i.wdata[31];
                    end
                    REG_TSF_LOAD_LO: load_lo_q <= reg_req_i.wdata;
                    REG_TSF_LOAD_HI: begin
                        load_hi_q  <= reg_req_i.wdata;
                        tsf_load_o <= 1'b1; // timer picks it up next edge
                    end
                    default: ; // read only or unmapped
                endcase
            end
        end
    end

    // live values are sampled in the request cycle
    always_comb begin
        case (addr)
            REG_SELF_MAC_LO: rd_mux = mac_lo_q;
            REG_SELF_MAC_HI: rd_mux = {promisc_q, 15'd0, mac_hi_q};
            REG_TSF_LOAD_LO: rd_mux = load_lo_q;
            REG_TSF_LOAD_HI: rd_mux = load_hi_q;
            REG_TSF_LO:      rd_mux = tsf_i[31:0];
            REG_TSF_HI:      rd_mux = tsf_i[63:32];
            REG_DROP_CNT:    rd_mux = drop_cnt_i;
            REG_VERSION:     rd_mux = `XPU_VERSION;
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reg_req_i.rd) begin
            rdata_o <= rd_mux;
        end
    end

    assign self_mac_o     = {mac_hi_q, mac_lo_q};
    assign promisc_o      = promisc_q;
    assign tsf_load_val_o = {load_hi_q, load_lo_q};

endmodule

`default_nettype wire

// File: source/mac_hdr_parse.sv
// 802.11 mac header parser for frame control, duration, addr1 and addr2
`default_nettype none

module mac_hdr_parse
    import xpu_pkg::*;
(
    input  wire             clk_i,
    input  wire             rst_n_i,
    input  wire             hdr_start_i,
    input  wire rx_byte_t   rx_byte_i,
    input  wire mac_addr_t  self_mac_i,
    output hdr_rec_t        rec_o,
    output logic            rec_valid_o
);

    localparam mac_addr_t BCAST_ADDR = '1;

    parse_state_e state_q;
    logic [3:0]   exp_idx_q;  // next header byte we want
    logic [31:0]  fc_q;
    mac_addr_t    addr1_q;
    mac_addr_t    addr2_q;
    logic         take;
    logic         for_me;
    logic [2:0]   a1_sel;
    logic [2:0]   a2_sel;

    // only in-order bytes of the first 16 are taken
    assign take = rx_byte_i.valid && (state_q != P_DONE)
                  && (rx_byte_i.idx == {12'd0, exp_idx_q});

    assign a1_sel = 3'(exp_idx_q - 4'd4);
    assign a2_sel = 3'(exp_idx_q - 4'd10);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q     <= P_IDLE;
            exp_idx_q   <= '0;
            rec_valid_o <= 1'b0;
        end else if (hdr_start_i) begin
            state_q     <= P_IDLE;
            exp_idx_q   <= '0;
            rec_valid_o <= 1'b0;
        end else begin
            rec_valid_o <= 1'b0;
            if (take) begin
                exp_idx_q <= exp_idx_q + 4'd1;
                case (state_q)
                    P_IDLE:  state_q <= P_FC;
                    P_FC:    if (exp_idx_q == 4'd3) state_q <= P_ADDR1;
                    P_ADDR1: if (exp_idx_q == 4'd9) state_q <= P_ADDR2;
                    P_ADDR2: begin
                        if (exp_idx_q == 4'd15) begin
                            state_q     <= P_DONE;
                            rec_valid_o <= 1'b1; // once per frame
                        end
                    end
                    default: state_q <= P_DONE;
                endcase
            end else if (rx_byte_i.valid && state_q != P_DONE) begin
                // a header byte went missing, give up on this frame
                state_q <= P_DONE;
            end
        end
    end

    // header fields land by position, no reset needed
    always_ff @(posedge clk_i) begin
        if (take) begin
            case (state_q)
                P_IDLE, P_FC: fc_q[exp_idx_q[1:0]*8 +: 8] <= rx_byte_i.data;
                P_ADDR1:      addr1_q[a1_sel*8 +: 8]      <= rx_byte_i.data;
                P_ADDR2:      addr2_q[a2_sel*8 +: 8]      <= rx_byte_i.data;
                default: ;
            endcase
        end
    end

    assign for_me = (addr1_q == self_mac_i) || (addr1_q == BCAST_ADDR);

    assign rec_o = '{
        fc:     frame_ctrl_t'(fc_q),
        addr1:  addr1_q,
        addr2:  addr2_q,
        for_me: for_me
    };

endmodule

`default_nettype wire

// File: source/hdr_report_queue.sv
// header record fifo with address filter, drop count and credit gated send
`default_nettype none

`include "xpu_config.svh"

module hdr_report_queue
    import xpu_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire hdr_rec_t               rec_i,
    input  wire                         rec_valid_i,
    input  wire                         promisc_i,
    input  wire                         credit_i,
    output hdr_rec_t                    rec_o,
    output logic                        valid_o,
    output logic [`XPU_REG_DATA_W-1:0]  drop_cnt_o
);

    localparam int DEPTH = `XPU_HDR_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CRD_W = $clog2(`XPU_HDR_CREDITS + 1);

    hdr_rec_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic [CRD_W-1:0] credit_cnt; // free slots at the consumer
    logic             accept;
    logic             full;
    logic             empty;
    logic             wr_en;
    logic             send;
    logic             drop;

    assign accept = rec_valid_i && (rec_i.for_me || promisc_i);
    assign full   = (count == (PTR_W+1)'(DEPTH));
    assign empty  = (count == '0);
    assign wr_en  = accept && !full;
    assign drop   = accept && full; // overflow only, filtered frames are not counted
    assign send   = !empty && (credit_cnt != '0);

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            mem[wr_ptr] <= rec_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_cnt <= CRD_W'(`XPU_HDR_CREDITS);
            drop_cnt_o <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1; // wraps, depth is a power of two
            if (send)  rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, send})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
            case ({send, credit_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: ; // send and return cancel out
            endcase
            if (drop && drop_cnt_o != '1) begin
                drop_cnt_o <= drop_cnt_o + 1'b1; // saturates
            end
        end
    end

    // head of fifo is presented straight away
    assign valid_o = send;
    assign rec_o   = mem[rd_ptr];

endmodule

`default_nettype wire

// File: source/xpu.sv
// xpu lower mac support top joining registers, tsf, header parser and report queue
`default_nettype none

`include "xpu_config.svh"

module xpu
    import xpu_pkg::*;
(
    input  wire                         clk_i,
    input  wire                         rst_n_i,
    input  wire reg_req_t               reg_req_i,
    input  wire rx_byte_t               rx_byte_i,
    input  wire                         hdr_start_i,
    input  wire                         hdr_credit_i,
    output logic [`XPU_REG_DATA_W-1:0]  reg_rdata_o,
    output logic                        reg_rvalid_o,
    output hdr_rec_t                    hdr_rec_o,
    output logic                        hdr_valid_o,
    output logic [`XPU_TSF_W-1:0]       tsf_o,
    output logic                        tsf_pulse_1m_o
);

    mac_addr_t                  self_mac;
    logic                       promisc;
    logic [`XPU_TSF_W-1:0]      tsf_load_val;
    logic                       tsf_load;
    logic [`XPU_REG_DATA_W-1:0] drop_cnt;
    hdr_rec_t                   rec;
    logic                       rec_valid;

    xpu_regs xpu_regs (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .reg_req_i      (reg_req_i),
        .tsf_i          (tsf_o),
        .drop_cnt_i     (drop_cnt),
        .rdata_o        (reg_rdata_o),
        .rvalid_o       (reg_rvalid_o),
        .self_mac_o     (self_mac),
        .promisc_o      (promisc),
        .tsf_load_val_o (tsf_load_val),
        .tsf_load_o     (tsf_load)
    );

    tsf_timer tsf_timer (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .load_i     (tsf_load),
        .load_val_i (tsf_load_val),
        .tsf_o      (tsf_o),
        .pulse_1m_o (tsf_pulse_1m_o)
    );

    mac_hdr_parse mac_hdr_parse (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .hdr_start_i (hdr_start_i),
        .rx_byte_i   (rx_byte_i),
        .self_mac_i  (self_mac),
        .rec_o       (rec),
        .rec_valid_o (rec_valid)
    );

    hdr_report_queue hdr_report_queue (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rec_i       (rec),
        .rec_valid_i (rec_valid),
        .promisc_i   (promisc),
        .credit_i    (hdr_credit_i),
        .rec_o       (hdr_rec_o),
        .valid_o     (hdr_valid_o),
        .drop_cnt_o  (drop_cnt)
    );

endmodule

`default_nettype wire

// File: testbench/xpu_assert.sv
// credit counter and microsecond pulse assertions bound into the xpu top
`default_nettype none

`include "xpu_config.svh"

module xpu_assert (
    input wire                                      clk_i,
    input wire                                      rst_n_i,
    input wire                                      valid_i,
    input wire                                      credit_ret_i,
    input wire [$clog2(`XPU_HDR_CREDITS + 1)-1:0]   credit_cnt_i,
    input wire                                      pulse_i
);

    int fail_cnt = 0; // read back by the testbench

    // a send with zero credits would wrap the counter past the grant
    send_takes_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        valid_i && !credit_ret_i |=> credit_cnt_i == $past(credit_cnt_i) - 1'b1)
        else begin
            $error("header record sent without consuming a credit");
            fail_cnt++;
        end

    credit_bounded: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        credit_cnt_i <= `XPU_HDR_CREDITS)
        else begin
            $error("credit count above the reset grant");
            fail_cnt++;
        end

    pulse_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        pulse_i |=> !pulse_i)
        else begin
            $error("microsecond pulse held for two cycles");
            fail_cnt++;
        end

endmodule

bind xpu xpu_assert xpu_assert (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .valid_i      (hdr_report_queue.valid_o),
    .credit_ret_i (hdr_report_queue.credit_i),
    .credit_cnt_i (hdr_report_queue.credit_cnt),
    .pulse_i      (tsf_timer.pulse_1m_o)
);

`default_nettype wire

// File: testbench/xpu_tb.sv
// xpu testbench with register traffic, tsf checks and a header record model
`default_nettype none

`include "xpu_config.svh"

module xpu_tb
    import xpu_pkg::*;
();

    localparam int PERIOD      = 20;
    localparam int HOLD_FRAMES = 10;
    localparam int DRAIN_LIMIT = 200;
    localparam int FRAME_CYC   = 40; // start strobe, 16 header bytes, payload, gap
    localparam int WATCHDOG    = (34 * FRAME_CYC + 2000) * PERIOD;
    localparam mac_addr_t BCAST = '1;

    logic        clk = 1'b0;
    logic        rst_n;
    reg_req_t    reg_req;
    rx_byte_t    rx_byte;
    logic        hdr_start;
    logic        hdr_credit;
    logic [31:0] reg_rdata;
    logic        reg_rvalid;
    hdr_rec_t    hdr_rec;
    logic        hdr_valid;
    logic [63:0] tsf;
    logic        tsf_pulse;

    logic [31:0] rng = 32'ha8e1_7998;
    hdr_rec_t    exp_q[$];           // records the model expects, oldest first
    int          unreturned = 0;     // delivered records still holding a credit
    int          delivered = 0;
    logic        return_en = 1'b1;
    mac_addr_t   self_mac = '0;
    logic        promisc = 1'b0;

    xpu dut (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .reg_req_i      (reg_req),
        .rx_byte_i      (rx_byte),
        .hdr_start_i    (hdr_start),
        .hdr_credit_i   (hdr_credit),
        .reg_rdata_o    (reg_rdata),
        .reg_rvalid_o   (reg_rvalid),
        .hdr_rec_o      (hdr_rec),
        .hdr_valid_o    (hdr_valid),
        .tsf_o          (tsf),
        .tsf_pulse_1m_o (tsf_pulse)
    );

    always #(PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] rand32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic mac_addr_t rand_mac();
        logic [63:0] r;
        r[31:0]  = rand32();
        r[63:32] = rand32();
        return r[47:0];
    endfunction

    // own address and broadcast show up often enough to exercise the filter
    function automatic mac_addr_t pick_addr1();
        logic [31:0] r;
        r = rand32() % 6;
        if (r < 2) return self_mac;
        if (r == 2) return BCAST;
        return rand_mac();
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got %h expected %h", name, got, exp);
            $display("Verification failed");
            $fatal(1);
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic reg_write(input reg_addr_e addr, input logic [31:0] data);
        @(negedge clk);
        reg_req = '{wr: 1'b1, rd: 1'b0, addr: addr, wdata: data};
        @(negedge clk);
        reg_req = '0;
    endtask

    // tsf_seen is what tsf_o holds while the request is on the bus
    task automatic reg_read(input reg_addr_e addr, output logic [31:0] data,
                            output logic [63:0] tsf_seen);
        @(negedge clk);
        check("reg_rvalid_o", reg_rvalid, 0); // no read in the cycle before
        reg_req  = '{wr: 1'b0, rd: 1'b1, addr: addr, wdata: '0};
        tsf_seen = tsf;
        @(negedge clk);
        reg_req = '0;
        check("reg_rvalid_o", reg_rvalid, 1);
        data = reg_rdata;
    endtask

    // gate low means the model knows the queue has no room for this one
    task automatic run_frame(input mac_addr_t a1, input logic gate);
        hdr_rec_t    rec;
        logic [31:0] fc;
        mac_addr_t   a2;
        int          extra;
        fc         = rand32();
        a2         = rand_mac();
        extra      = int'(rand32() % 8);
        rec.fc     = frame_ctrl_t'(fc);
        rec.addr1  = a1;
        rec.addr2  = a2;
        rec.for_me = (a1 == self_mac) || (a1 == BCAST);
        if ((rec.for_me || promisc) && gate) exp_q.push_back(rec);
        @(negedge clk);
        hdr_start = 1'b1;
        @(negedge clk);
        hdr_start = 1'b0;
        for (int i = 0; i < 16 + extra; i++) begin
            rx_byte.valid = 1'b1;
            rx_byte.idx   = 16'(i);
            if (i < 4) rx_byte.data = fc[8*i +: 8];
            else if (i < 10) rx_byte.data = a1[8*(i-4) +: 8];
            else if (i < 16) rx_byte.data = a2[8*(i-10) +: 8];
            else rx_byte.data = 8'(rand32()); // payload, ignored by the parser
            @(negedge clk);
        end
        rx_byte = '0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((exp_q.size() != 0 || unreturned != 0) && n < DRAIN_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (n >= DRAIN_LIMIT) fail_run("timed out waiting for header records to drain");
    endtask

    always @(posedge clk) begin
        hdr_rec_t want;
        if (rst_n && hdr_valid) begin
            if (exp_q.size() == 0) begin
                fail_run("header record reported that the model did not predict");
            end else begin
                want = exp_q.pop_front();
                check("hdr_rec_o.fc", hdr_rec.fc, want.fc);
                check("hdr_rec_o.addr1", hdr_rec.addr1, want.addr1);
                check("hdr_rec_o.addr2", hdr_rec.addr2, want.addr2);
                check("hdr_rec_o.for_me", hdr_rec.for_me, want.for_me);
                delivered++;
                unreturned++;
            end
        end
    end

    always @(posedge clk) begin
        if (dut.xpu_assert.fail_cnt != 0) begin
            fail_run("an assertion in the bound checker failed");
        end
    end

    // consumer hands back one credit per cycle while allowed
    always @(negedge clk) begin
        if (return_en && unreturned > 0) begin
            hdr_credit = 1'b1;
            unreturned--;
        end else begin
            hdr_credit = 1'b0;
        end
    end

    initial begin
        #(WATCHDOG);
        fail_run("watchdog expired before the tests completed");
    end

    initial begin
        logic [31:0] rd;
        logic [63:0] snap;
        logic [63:0] load;
        logic [63:0] exp_tsf;
        int          cyc;
        int          pulses;
        int          base;
        rst_n      = 1'b0;
        reg_req    = '0;
        rx_byte    = '0;
        hdr_start  = 1'b0;
        hdr_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check("tsf_o", tsf, 0);
        check("hdr_valid_o", hdr_valid, 0);
        check("reg_rvalid_o", reg_rvalid, 0);
        check("tsf_pulse_1m_o", tsf_pulse, 0);

        self_mac = rand_mac();
        reg_write(REG_SELF_MAC_LO, self_mac[31:0]);
        reg_write(REG_SELF_MAC_HI, {16'd0, self_mac[47:32]});
        reg_read(REG_SELF_MAC_LO, rd, snap);
        check("reg_rdata_o", rd, self_mac[31:0]);
        reg_read(REG_SELF_MAC_HI, rd, snap);
        check("reg_rdata_o", rd, {16'd0, self_mac[47:32]});
        reg_read(REG_VERSION, rd, snap);
        check("reg_rdata_o", rd, `XPU_VERSION);

        load[31:0]  = rand32();
        load[63:32] = rand32();
        reg_write(REG_TSF_LOAD_LO, load[31:0]);
        reg_write(REG_TSF_LOAD_HI, load[63:32]);
        @(negedge clk); // second cycle after the request
        check("tsf_o", tsf, load);
        exp_tsf = load;
        cyc     = 0;
        pulses  = 0;
        for (int i = 0; i < 3 * `XPU_CLK_PER_US + 5; i++) begin
            @(negedge clk);
            cyc++;
            if (tsf_pulse) begin
                check("tsf_pulse_1m_o spacing", cyc, `XPU_CLK_PER_US);
                exp_tsf++;
                cyc = 0;
                pulses++;
            end
            check("tsf_o", tsf, exp_tsf);
        end
        check("tsf_pulse_1m_o count", pulses, 3);
        reg_read(REG_TSF_LO, rd, snap);
        check("reg_rdata_o", rd, snap[31:0]);
        reg_read(REG_TSF_HI, rd, snap);
        check("reg_rdata_o", rd, snap[63:32]);

        // filtered frames first, then promiscuous
        for (int i = 0; i < 24; i++) begin
            if (i == 12) begin
                wait_drain();
                promisc = 1'b1;
                reg_write(REG_SELF_MAC_HI, {1'b1, 15'd0, self_mac[47:32]});
            end
            run_frame(pick_addr1(), 1'b1);
        end
        wait_drain();

        promisc = 1'b0;
        reg_write(REG_SELF_MAC_HI, {16'd0, self_mac[47:32]});
        return_en = 1'b0;
        base      = delivered;
        for (int i = 0; i < HOLD_FRAMES; i++) begin
            run_frame(self_mac, i < `XPU_HDR_CREDITS + `XPU_HDR_QUEUE_DEPTH);
        end
        repeat (5) @(negedge clk);
        check("hdr_valid_o count", delivered - base, `XPU_HDR_CREDITS);
        check("queued records", exp_q.size(), `XPU_HDR_QUEUE_DEPTH);
        reg_read(REG_DROP_CNT, rd, snap);
        check("reg_rdata_o", rd, HOLD_FRAMES - `XPU_HDR_CREDITS - `XPU_HDR_QUEUE_DEPTH);
        return_en = 1'b1;
        wait_drain();

        repeat (10) @(negedge clk);
        if (dut.xpu_assert.fail_cnt != 0) begin
            $display("%0d assertion failures were flagged", dut.xpu_assert.fail_cnt);
            $display("Verification failed");
            $fatal(1);
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
source/xpu_pkg.sv
source/tsf_timer.sv
source/xpu_regs.sv
source/mac_hdr_parse.sv
source/hdr_report_queue.sv
source/xpu.sv
testbench/xpu_assert.sv
testbench/xpu_tb.sv
